// File: sources.f
hw/cam_pkg.sv
hw/report_pkg.sv
hw/cam_input.sv
hw/centroid_accum.sv
hw/report_sender.sv
hw/uart_tx.sv
hw/eye_tracker_top.sv
bench/tb_eye_tracker.sv

// File: Makefile
SIM      = verilator
TOP      = tb_eye_tracker
FILELIST = sources.f
OBJDIR   = obj_dir
SIMFLAGS = --binary --timing -Wno-fatal --top-module $(TOP) --Mdir $(OBJDIR)
PASS_MSG = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIMFLAGS) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// File: bench/tb_eye_tracker.sv
// ------------------------------
// Eye tracker testbench
// Drives camera frames into the top level, decodes the
// UART report and compares it with sums worked out from
// the pixel data while each frame is sent
// ------------------------------
`default_nettype none

module tb_eye_tracker
    import cam_pkg::*;
    import report_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_LINES     = 8;
    localparam int MAX_BEATS     = 16;
    localparam int START_TIMEOUT = 8 * CLKS_PER_BIT;
    localparam int BUSY_TIMEOUT  = 4 * CLKS_PER_BIT;

    logic   cclk;
    logic   rst_n;
    logic   fval;
    logic   lval;
    logic   dval;
    pixel_t data_l;
    pixel_t data_r;
    pixel_t threshold;
    logic   uart_txd;

    pixel_t      frame_pix [0:MAX_LINES-1][0:2*MAX_BEATS-1];
    logic [31:0] exp_s;     // Sums of the last frame sent
    logic [31:0] exp_sx;
    logic [31:0] exp_sy;
    int          errors;
    int          checks;
    int          seed;

    eye_tracker_top uut (
        .cclk      (cclk),
        .rst_n     (rst_n),
        .fval      (fval),
        .lval      (lval),
        .dval      (dval),
        .data_l    (data_l),
        .data_r    (data_r),
        .threshold (threshold),
        .uart_txd  (uart_txd)
    );

    initial begin
        cclk = 1'b0;
        forever #2 cclk = ~cclk;
    end

    // Helpers -----------------------
    task automatic advance();
        @(posedge cclk);
        #1;
    endtask

    task automatic fill_frame(input pixel_t value);
        int ln;
        int p;
        for (ln = 0; ln < MAX_LINES; ln++) begin
            for (p = 0; p < 2 * MAX_BEATS; p++) begin
                frame_pix[ln][p] = value;
            end
        end
    endtask

    // One frame with a stall beat before every dval_gap-th beat
    task automatic send_frame(input int lines, input int beats, input pixel_t thr,
                              input int dval_gap, input int line_gap);
        int ln;
        int bt;
        int g;
        exp_s  = '0;
        exp_sx = '0;
        exp_sy = '0;
        advance();
        threshold = thr;
        fval      = 1'b1;
        for (ln = 0; ln < lines; ln++) begin
            for (bt = 0; bt < beats; bt++) begin
                if (dval_gap > 0 && bt > 0 && bt % dval_gap == 0) begin
                    advance();
                    lval   = 1'b1;
                    dval   = 1'b1;      // Inactive so dark data must not count
                    data_l = 8'd0;
                    data_r = 8'd0;
                end
                advance();
                lval   = 1'b1;
                dval   = 1'b0;
                data_l = frame_pix[ln][2*bt];
                data_r = frame_pix[ln][2*bt+1];
                if (frame_pix[ln][2*bt] < thr) begin
                    exp_s  = exp_s + 32'd1;
                    exp_sx = exp_sx + 32'(2 * bt);
                    exp_sy = exp_sy + 32'(ln);
                end
                if (frame_pix[ln][2*bt+1] < thr) begin
                    exp_s  = exp_s + 32'd1;
                    exp_sx = exp_sx + 32'(2 * bt + 1);
                    exp_sy = exp_sy + 32'(ln);
                end
            end
            for (g = 0; g <= line_gap; g++) begin
                advance();
                lval = 1'b0;
                dval = 1'b1;
            end
        end
        advance();
        fval = 1'b0;
    endtask

    // UART decode -------------------
    task automatic receive_byte(output byte_t value, output bit ok);
        int n;
        int i;
        ok    = 1'b0;
        value = '0;
        n     = 0;
        while (uart_txd !== 1'b0 && n < START_TIMEOUT) begin
            @(negedge cclk);
            n++;
        end
        if (uart_txd !== 1'b0) begin
            errors++;
            $display("No UART start bit within the timeout at %0t", $time);
            return;
        end
        repeat (CLKS_PER_BIT / 2) @(negedge cclk);   // Middle of the start bit
        checks++;
        if (uart_txd !== 1'b0) begin
            errors++;
            $display("ERR %0t uart_txd start bit expected 0 got %b", $time, uart_txd);
            return;
        end
        for (i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge cclk);
            value[i] = uart_txd;
        end
        repeat (CLKS_PER_BIT) @(negedge cclk);
        checks++;
        if (uart_txd !== 1'b1) begin
            errors++;
            $display("ERR %0t uart_txd stop bit expected 1 got %b", $time, uart_txd);
            return;
        end
        ok = 1'b1;
    endtask

    task automatic receive_report(input logic [31:0] s, input logic [31:0] sx,
                                  input logic [31:0] sy, input string label);
        byte_t exp_b [REPORT_BYTES];
        byte_t got;
        bit    ok;
        int    i;
        exp_b[0] = REPORT_SYNC;
        for (i = 0; i < 3; i++) begin
            exp_b[1+i] = byte_t'(s >> (16 - 8 * i));    // 24 bit count sent MSB first
        end
        for (i = 0; i < 4; i++) begin
            exp_b[4+i] = byte_t'(sx >> (24 - 8 * i));
            exp_b[8+i] = byte_t'(sy >> (24 - 8 * i));
        end
        for (i = 0; i < REPORT_BYTES; i++) begin
            receive_byte(got, ok);
            if (!ok) begin
                $display("Report for %s stopped at byte %0d", label, i);
                return;
            end
            checks++;
            if (got !== exp_b[i]) begin
                errors++;
                $display("ERR %0t %s report[%0d] expected %02h got %02h",
                         $time, label, i, exp_b[i], got);
            end
        end
    endtask

    task automatic wait_report_done();
        int n;
        n = 0;
        while (uut.busy !== 1'b0 && n < BUSY_TIMEOUT) begin
            @(negedge cclk);
            n++;
        end
        checks++;
        if (uut.busy !== 1'b0) begin
            errors++;
            $display("Report sender still busy after the timeout at %0t", $time);
        end
    endtask

    task automatic check_line_idle(input int bits, input string label);
        int n;
        bit seen_low;
        seen_low = 1'b0;
        for (n = 0; n < bits * CLKS_PER_BIT; n++) begin
            @(negedge cclk);
            if (uart_txd !== 1'b1) begin
                seen_low = 1'b1;
            end
        end
        checks++;
        if (seen_low) begin
            errors++;
            $display("UART line left idle %s at %0t", label, $time);
        end
    endtask

    task automatic send_and_check(input int lines, input int beats, input pixel_t thr,
                                  input int dval_gap, input int line_gap,
                                  input string label);
        send_frame(lines, beats, thr, dval_gap, line_gap);
        receive_report(exp_s, exp_sx, exp_sy, label);
        wait_report_done();
    endtask

    // Tests -------------------------
    task automatic set_known_darks();
        fill_frame(8'd200);
        frame_pix[0][1]  = 8'd10;   // Right tap of beat 0
        frame_pix[1][4]  = 8'd20;
        frame_pix[2][15] = 8'd30;
        frame_pix[3][0]  = 8'd0;
        frame_pix[3][7]  = 8'd99;
    endtask

    task automatic test_threshold_edge();
        fill_frame(8'd200);
        frame_pix[0][2]  = 8'd100;
        frame_pix[1][5]  = 8'd100;
        frame_pix[2][9]  = 8'd99;
        frame_pix[3][14] = 8'd100;
        frame_pix[3][15] = 8'd99;
        send_and_check(4, 8, 8'd100, 0, 1, "threshold equal");
        send_and_check(4, 8, 8'd101, 0, 1, "threshold raised");
    endtask

    task automatic test_busy_drop();
        logic [31:0] a_s;
        logic [31:0] a_sx;
        logic [31:0] a_sy;
        fill_frame(8'd200);
        frame_pix[0][3] = 8'd5;
        frame_pix[2][8] = 8'd5;
        send_frame(4, 8, 8'd100, 0, 1);
        a_s  = exp_s;
        a_sx = exp_sx;
        a_sy = exp_sy;
        fork
            receive_report(a_s, a_sx, a_sy, "frame before drop");
            begin
                repeat (50) advance();
                frame_pix[1][1] = 8'd7;
                send_frame(4, 8, 8'd100, 0, 1);
                checks++;
                if (uut.busy !== 1'b1) begin
                    errors++;
                    $display("ERR %0t busy expected 1 got %b", $time, uut.busy);
                end
            end
        join
        wait_report_done();
        check_line_idle(3, "after the dropped frame");
        fill_frame(8'd200);
        frame_pix[3][12] = 8'd1;
        send_and_check(4, 8, 8'd100, 0, 1, "frame after drop");
    endtask

    task automatic test_random_frame();
        pixel_t thr;
        int     ln;
        int     p;
        for (ln = 0; ln < MAX_LINES; ln++) begin
            for (p = 0; p < 2 * MAX_BEATS; p++) begin
                frame_pix[ln][p] = pixel_t'($random(seed));
            end
        end
        thr = 8'h40 | (pixel_t'($random(seed)) & 8'h7f);
        send_and_check(MAX_LINES, MAX_BEATS, thr, 5, 2, "random frame");
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        seed      = 32'hd248;
        rst_n     = 1'b0;
        fval      = 1'b0;
        lval      = 1'b0;
        dval      = 1'b1;
        data_l    = '0;
        data_r    = '0;
        threshold = '0;
        repeat (16) @(posedge cclk);
        #1;
        rst_n = 1'b1;

        check_line_idle(3, "after reset");
        set_known_darks();
        send_and_check(4, 8, 8'd100, 0, 1, "known pixels");
        test_threshold_edge();
        set_known_darks();
        send_and_check(5, 8, 8'd100, 3, 6, "dval and line gaps");
        test_busy_drop();
        test_random_frame();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/eye_tracker_top.sv
// ------------------------------
// Eye tracker top level
// Camera input, pupil accumulation and the serial
// report, all in the camera clock domain
// ------------------------------
`default_nettype none

module eye_tracker_top
    import cam_pkg::*;
    import report_pkg::*;
(
    input  wire          cclk,
    input  wire          rst_n,
    input  wire          fval,
    input  wire          lval,
    input  wire          dval,
    input  wire pixel_t  data_l,
    input  wire pixel_t  data_r,
    input  wire pixel_t  threshold,
    output logic         uart_txd
);

    // Camera side
    logic    beat_valid;
    pixel_t  pix_l;
    pixel_t  pix_r;
    beat_t   beat_x;
    coord_t  row;
    logic    frame_end;

    // Result and report side
    logic    result_valid;
    sum_s_t  res_s;
    sum_sx_t res_sx;
    sum_sy_t res_sy;
    logic    busy;
    logic    tx_start;
    byte_t   tx_data;
    logic    tx_busy;

    cam_input u_cam_input (
        .cclk       (cclk),
        .rst_n      (rst_n),
        .fval       (fval),
        .lval       (lval),
        .dval       (dval),
        .data_l     (data_l),
        .data_r     (data_r),
        .beat_valid (beat_valid),
        .pix_l      (pix_l),
        .pix_r      (pix_r),
        .beat_x     (beat_x),
        .row        (row),
        .frame_end  (frame_end)
    );

    centroid_accum u_centroid_accum (
        .cclk         (cclk),
        .rst_n        (rst_n),
        .beat_valid   (beat_valid),
        .pix_l        (pix_l),
        .pix_r        (pix_r),
        .beat_x       (beat_x),
        .row          (row),
        .frame_end    (frame_end),
        .threshold    (threshold),
        .busy         (busy),       // Frames ending during a report are dropped
        .result_valid (result_valid),
        .res_s        (res_s),
        .res_sx       (res_sx),
        .res_sy       (res_sy)
    );

    report_sender u_report_sender (
        .cclk         (cclk),
        .rst_n        (rst_n),
        .result_valid (result_valid),
        .res_s        (res_s),
        .res_sx       (res_sx),
        .res_sy       (res_sy),
        .tx_busy      (tx_busy),
        .busy         (busy),
        .tx_start     (tx_start),
        .tx_data      (tx_data)
    );

    uart_tx u_uart_tx (
        .cclk     (cclk),
        .rst_n    (rst_n),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_busy  (tx_busy),
        .uart_txd (uart_txd)
    );

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
// ------------------------------
// UART transmitter, 8N1
// One byte per tx_start, LSB first, each bit held
// for CLKS_PER_BIT camera clocks
// ------------------------------
`default_nettype none

module uart_tx
    import report_pkg::*;
(
    input  wire          cclk,
    input  wire          rst_n,
    input  wire          tx_start,
    input  wire byte_t   tx_data,
    output logic         tx_busy,
    output logic         uart_txd
);

    logic [$bits(CLKS_PER_BIT)-1:0]    clk_cnt;   // Cycles within a bit
    logic [$clog2(UART_FRAME_BITS)-1:0] bit_cnt;   // Bit within the frame
    logic [UART_FRAME_BITS-1:0]        shift_q;   // LSB is on the line

    assign uart_txd = shift_q[0];

    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            tx_busy <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
            shift_q <= '1;                        // Line idles high
        end else if (!tx_busy) begin
            clk_cnt <= '0;
            bit_cnt <= '0;
            if (tx_start) begin
                shift_q <= {1'b1, tx_data, 1'b0}; // Stop, data, start
                tx_busy <= 1'b1;
            end
        end else if (clk_cnt == CLKS_PER_BIT - 1'b1) begin
            clk_cnt <= '0;
            if (bit_cnt == UART_FRAME_BITS - 1) begin
                tx_busy <= 1'b0;                  // Stop bit stays on the line
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
                shift_q <= {1'b1, shift_q[UART_FRAME_BITS-1:1]};
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/report_sender.sv
// ------------------------------
// Report sequencer
// Takes one frame's sums on result_valid and feeds
// the 12 report bytes to the UART one at a time.
// busy covers the whole transfer
// ------------------------------
`default_nettype none

module report_sender
    import report_pkg::*;
(
    input  wire           cclk,
    input  wire           rst_n,
    input  wire           result_valid,
    input  wire sum_s_t   res_s,
    input  wire sum_sx_t  res_sx,
    input  wire sum_sy_t  res_sy,
    input  wire           tx_busy,
    output logic          busy,
    output logic          tx_start,
    output byte_t         tx_data
);

    typedef enum logic [1:0] {
        idle,
        load,       // Hand the next byte to the UART
        wait_tx,    // Byte on the line
        done
    } state_t;

    state_t    state;
    report_t   report_sr;
    byte_idx_t byte_idx;

    assign busy     = (state != idle);
    assign tx_start = (state == load) && !tx_busy;
    assign tx_data  = report_sr[REPORT_BITS-1 -: $bits(byte_t)];   // Top byte goes next

    // FSM ---------------------------
    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            state    <= idle;
            byte_idx <= '0;
        end else begin
            case (state)
                idle: begin
                    if (result_valid) begin
                        byte_idx <= '0;
                        state    <= load;
                    end
                end
                load: begin
                    if (!tx_busy) begin
                        state <= wait_tx;
                    end
                end
                wait_tx: begin
                    // UART has raised tx_busy by the first cycle here
                    if (!tx_busy) begin
                        if (byte_idx == byte_idx_t'(REPORT_BYTES - 1)) begin
                            state <= done;
                        end else begin
                            byte_idx <= byte_idx + byte_idx_t'(1);
                            state    <= load;
                        end
                    end
                end
                done:    state <= idle;
                default: state <= idle;
            endcase
        end
    end

    // Report shift register
    always_ff @(posedge cclk) begin
        if (state == idle && result_valid) begin
            report_sr <= {REPORT_SYNC,
                          S_FIELD_BITS'(res_s),
                          SX_FIELD_BITS'(res_sx),
                          SY_FIELD_BITS'(res_sy)};
        end else if (state == wait_tx && !tx_busy) begin
            report_sr <= {report_sr[REPORT_BITS-$bits(byte_t)-1:0], byte_t'(0)};
        end
    end

endmodule

`default_nettype wire

// File: hw/centroid_accum.sv
// ------------------------------
// Pupil moment accumulator
// Counts pixels darker than the threshold and sums
// their x and y over a frame. Sums are latched at
// frame end unless the report path is still busy
// ------------------------------
`default_nettype none

module centroid_accum
    import cam_pkg::*;
    import report_pkg::*;
(
    input  wire          cclk,
    input  wire          rst_n,
    input  wire          beat_valid,
    input  wire pixel_t  pix_l,
    input  wire pixel_t  pix_r,
    input  wire beat_t   beat_x,
    input  wire coord_t  row,
    input  wire          frame_end,
    input  wire pixel_t  threshold,
    input  wire          busy,
    output logic         result_valid,
    output sum_s_t       res_s,
    output sum_sx_t      res_sx,
    output sum_sy_t      res_sy
);

    logic                dark_l;
    logic                dark_r;
    coord_t              x_l;
    coord_t              x_r;
    logic [1:0]          add_s;
    logic [COORD_BITS:0] add_sx;   // Two coordinates need one extra bit
    logic [COORD_BITS:0] add_sy;

    sum_s_t              acc_s;
    sum_sx_t             acc_sx;
    sum_sy_t             acc_sy;

    // Per beat terms ----------------
    assign dark_l = (pix_l < threshold);
    assign dark_r = (pix_r < threshold);   // Equal to threshold is not dark

    assign x_l = {beat_x, 1'b0};
    assign x_r = {beat_x, 1'b1};

    assign add_s  = {1'b0, dark_l} + {1'b0, dark_r};
    assign add_sx = (dark_l ? {1'b0, x_l} : '0) + (dark_r ? {1'b0, x_r} : '0);

    // Row counted once per dark pixel
    always_comb begin
        case ({dark_l, dark_r})
            2'b11:   add_sy = {row, 1'b0};
            2'b10,
            2'b01:   add_sy = {1'b0, row};
            default: add_sy = '0;
        endcase
    end

    // Accumulators ------------------
    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            acc_s        <= '0;
            acc_sx       <= '0;
            acc_sy       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= frame_end & ~busy;   // Dropped frame gives no pulse
            if (frame_end) begin
                acc_s  <= '0;
                acc_sx <= '0;
                acc_sy <= '0;
            end else if (beat_valid) begin
                acc_s  <= acc_s + sum_s_t'(add_s);
                acc_sx <= acc_sx + sum_sx_t'(add_sx);
                acc_sy <= acc_sy + sum_sy_t'(add_sy);
            end
        end
    end

    // Result latch, valid with result_valid
    always_ff @(posedge cclk) begin
        if (frame_end && !busy) begin
            res_s  <= acc_s;
            res_sx <= acc_sx;
            res_sy <= acc_sy;
        end
    end

endmodule

`default_nettype wire

// File: hw/cam_input.sv
// ------------------------------
// Camera Link input stage
// Registers the tap data and qualifiers, maps them
// to active high and tracks beat and row position.
// Outputs lag the pins by one cycle
// ------------------------------
`default_nettype none

module cam_input
    import cam_pkg::*;
(
    input  wire          cclk,
    input  wire          rst_n,
    input  wire          fval,
    input  wire          lval,
    input  wire          dval,
    input  wire pixel_t  data_l,
    input  wire pixel_t  data_r,
    output logic         beat_valid,
    output pixel_t       pix_l,
    output pixel_t       pix_r,
    output beat_t        beat_x,
    output coord_t       row,
    output logic         frame_end
);

    logic fval_r;   // Active high after polarity
    logic lval_r;
    logic dval_r;
    logic fval_q;   // One cycle older, for edges
    logic lval_q;
    logic lval_fall;

    // Qualifier capture -------------
    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            fval_r <= 1'b0;
            lval_r <= 1'b0;
            dval_r <= 1'b0;
            fval_q <= 1'b0;
            lval_q <= 1'b0;
        end else begin
            fval_r <= (fval == FVAL_ACTIVE);
            lval_r <= (lval == LVAL_ACTIVE);
            dval_r <= (dval == DVAL_ACTIVE);
            fval_q <= fval_r;
            lval_q <= lval_r;
        end
    end

    // Pixel data of both taps
    always_ff @(posedge cclk) begin
        pix_l <= data_l;
        pix_r <= data_r;
    end

    assign beat_valid = fval_r & lval_r & dval_r;
    assign lval_fall  = lval_q & ~lval_r;
    assign frame_end  = fval_q & ~fval_r;      // First cycle out of the frame

    // Position counters -------------
    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            beat_x <= '0;
            row    <= '0;
        end else begin
            // Held at zero between lines, so each line starts at beat 0
            if (!lval_r) begin
                beat_x <= '0;
            end else if (beat_valid) begin
                beat_x <= beat_x + beat_t'(1);
            end

            if (!fval_r) begin
                row <= '0;                     // Ready for the next frame
            end else if (lval_fall) begin
                row <= row + coord_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/report_pkg.sv
// ------------------------------
// Report and UART definitions
// Moment sum types, byte layout of the serial
// report and the UART bit timing in camera clocks
// ------------------------------
`default_nettype none

package report_pkg;

    // Moment sums -------------------
    localparam int SUM_S_BITS  = 20;
    localparam int SUM_SX_BITS = 28;
    localparam int SUM_SY_BITS = 28;

    typedef logic [SUM_S_BITS-1:0]  sum_s_t;
    typedef logic [SUM_SX_BITS-1:0] sum_sx_t;
    typedef logic [SUM_SY_BITS-1:0] sum_sy_t;

    // Report layout -----------------
    // Sync byte, then count, x sum and y sum, MSB first
    localparam int S_FIELD_BITS  = 24;
    localparam int SX_FIELD_BITS = 32;
    localparam int SY_FIELD_BITS = 32;

    localparam int unsigned REPORT_BYTES = 12;
    localparam int REPORT_BITS  = REPORT_BYTES * 8;

    typedef logic [7:0]             byte_t;
    typedef logic [3:0]             byte_idx_t;
    typedef logic [REPORT_BITS-1:0] report_t;

    localparam byte_t REPORT_SYNC = 8'hA5;

    // UART timing -------------------
    localparam logic [15:0] CLKS_PER_BIT    = 16'd217;  // 230400 baud at 50 MHz
    localparam int          UART_FRAME_BITS = 10;       // Start, 8 data, stop

endpackage

`default_nettype wire

// File: hw/cam_pkg.sv
// ------------------------------
// Camera side definitions
// Pixel and coordinate types plus the fixed
// Camera Link qualifier polarities, shared by
// the input stage and the centroid logic
// ------------------------------
`default_nettype none

package cam_pkg;

    // Widths ------------------------
    localparam int PIXEL_BITS = 8;
    localparam int COORD_BITS = 10;             // Up to 1024 columns or rows
    localparam int BEAT_BITS  = COORD_BITS - 1; // Two pixels per beat

    typedef logic [PIXEL_BITS-1:0] pixel_t;
    typedef logic [COORD_BITS-1:0] coord_t;
    typedef logic [BEAT_BITS-1:0]  beat_t;

    // Qualifier polarity ------------
    // Compared against the raw pins, a match means active
    localparam logic FVAL_ACTIVE = 1'b1;
    localparam logic LVAL_ACTIVE = 1'b1;
    localparam logic DVAL_ACTIVE = 1'b0;        // Data valid is low on this camera

endpackage

`default_nettype wire
